/* build.f */
logic/cpu_pkg.sv
logic/pipe_if.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/top_cpu.sv
test/top_cpu_properties.sv
test/top_cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the top_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module top_cpu_tb -f build.f -o top_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/top_cpu_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -qx "TEST OK" "$log_file"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $log_file"
    exit 1
fi

echo "Simulation passed"
exit 0

/* test/top_cpu_tb.sv */
module top_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 16;
    localparam int halt_timeout = 500;
    localparam int settle_cycles = 4;
    localparam int prog_len = 34;
    // EBREAK is word 29 and needs four more edges to reach MEM/WB
    localparam int earliest_halt = 33;

    localparam logic [6:0] opc_imm  = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [2:0] f3_add   = 3'b000;
    localparam logic [2:0] f3_slt   = 3'b010;
    localparam logic [2:0] f3_xor   = 3'b100;
    localparam logic [2:0] f3_or    = 3'b110;
    localparam logic [2:0] f3_and   = 3'b111;
    localparam logic [2:0] f3_beq   = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [31:0] nop_word    = 32'h0000_0013;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // Register contents after the run, worked out by hand, x0 to x31
    localparam logic [31:0] expected_regs [32] = '{
        32'd0, 32'd6, 32'd15, 32'd21, 32'd15, 32'd5, 32'd23, 32'd24,
        32'd1, 32'd0, 32'hFFFF_FFFD, 32'd1, 32'd24, 32'd30, 32'd30, 32'hFFFF_FFE8,
        32'd6, 32'd0, 32'd0, 32'd0, 32'd0, 32'd7, 32'd9, 32'd0,
        32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0
    };

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        imem_we;
    logic [5:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic        halted;
    logic [31:0] program_words [prog_len];
    int          halt_cycles;

    top_cpu u_top_cpu (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data),
        .halted     (halted)
    );

    bind top_cpu top_cpu_properties u_properties (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .halted   (halted),
        .x0_value (u_decode.regs[0])
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input int rd, input int rs1, input int rs2);
        return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), funct3, 5'(rd), opcode};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] s_type(input int rs2, input int rs1, input int imm);
        logic [11:0] s;
        s = 12'(imm);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] funct3, input int rs1,
                                           input int rs2, input int imm);
        logic [12:0] b;
        b = 13'(imm);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), funct3, b[4:1], b[11], 7'b1100011};
    endfunction

    task automatic build_program();
        program_words[0]  = i_type(opc_imm, f3_add, 1, 0, 6);       // addi x1, x0, 6
        program_words[1]  = i_type(opc_imm, f3_add, 2, 1, 9);       // addi x2, x1, 9
        program_words[2]  = r_type(7'h00, f3_add, 3, 1, 2);         // add  x3, x1, x2
        program_words[3]  = r_type(7'h20, f3_add, 4, 3, 1);         // sub  x4, x3, x1
        program_words[4]  = r_type(7'h00, f3_and, 5, 3, 2);         // and  x5, x3, x2
        program_words[5]  = r_type(7'h00, f3_or, 6, 3, 1);          // or   x6, x3, x1
        program_words[6]  = r_type(7'h00, f3_xor, 7, 6, 2);         // xor  x7, x6, x2
        program_words[7]  = r_type(7'h00, f3_slt, 8, 1, 7);         // slt  x8, x1, x7
        program_words[8]  = r_type(7'h00, f3_slt, 9, 7, 1);         // slt  x9, x7, x1
        program_words[9]  = i_type(opc_imm, f3_add, 10, 0, -3);     // addi x10, x0, -3
        program_words[10] = r_type(7'h00, f3_slt, 11, 10, 1);       // slt  x11, x10, x1
        program_words[11] = s_type(7, 0, 8);                        // sw   x7, 8(x0)
        program_words[12] = i_type(opc_load, f3_word, 12, 0, 8);    // lw   x12, 8(x0)
        program_words[13] = r_type(7'h00, f3_add, 13, 12, 1);       // add  x13, x12, x1
        program_words[14] = s_type(13, 4, 1);                       // sw   x13, 1(x4)
        program_words[15] = i_type(opc_load, f3_word, 14, 0, 16);   // lw   x14, 16(x0)
        program_words[16] = r_type(7'h20, f3_add, 15, 1, 14);       // sub  x15, x1, x14
        program_words[17] = i_type(opc_imm, f3_add, 0, 0, 99);      // addi x0, x0, 99
        program_words[18] = r_type(7'h00, f3_add, 16, 0, 1);        // add  x16, x0, x1
        program_words[19] = b_type(f3_beq, 1, 1, 12);               // beq  x1, x1, +12
        program_words[20] = i_type(opc_imm, f3_add, 17, 0, 1);
        program_words[21] = i_type(opc_imm, f3_add, 18, 0, 1);
        program_words[22] = b_type(f3_bne, 1, 2, 12);               // bne  x1, x2, +12
        program_words[23] = i_type(opc_imm, f3_add, 19, 0, 1);
        program_words[24] = i_type(opc_imm, f3_add, 20, 0, 1);
        program_words[25] = b_type(f3_beq, 1, 2, 8);                // not taken
        program_words[26] = i_type(opc_imm, f3_add, 21, 0, 7);      // addi x21, x0, 7
        program_words[27] = b_type(f3_bne, 1, 1, 8);                // not taken
        program_words[28] = i_type(opc_imm, f3_add, 22, 0, 9);      // addi x22, x0, 9
        program_words[29] = ebreak_word;
        // Past the EBREAK, must never commit
        program_words[30] = i_type(opc_imm, f3_add, 23, 0, 1);
        program_words[31] = i_type(opc_imm, f3_add, 24, 0, 1);
        program_words[32] = nop_word;
        program_words[33] = nop_word;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            #1;
            imem_we    = 1'b1;
            imem_addr  = 6'(i);
            imem_wdata = program_words[i];
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic wait_for_halt(output int cycles);
        cycles = 0;
        while (halted !== 1'b1) begin
            if (cycles >= halt_timeout) begin
                $display("Timeout: the core did not halt within %0d cycles", halt_timeout);
                $display("TEST FAILED");
                $fatal(1);
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            dbg_addr = 5'(r);
            @(negedge clk);
            assert (dbg_data == expected_regs[r]) else begin
                $display("[ERROR] %0t ns: dbg_data (x%0d) is %h, expected %h",
                         $time, r, dbg_data, expected_regs[r]);
                $display("TEST FAILED");
                $fatal(1);
            end
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        dbg_addr   = '0;
        build_program();

        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        assert (halted == 1'b0) else begin
            $display("[ERROR] %0t ns: halted is %b, expected %b", $time, halted, 1'b0);
            $display("TEST FAILED");
            $fatal(1);
        end

        load_program();
        @(posedge clk);
        #1;
        run = 1'b1;

        wait_for_halt(halt_cycles);
        assert (halt_cycles >= earliest_halt) else begin
            $display("The core halted after %0d cycles, before the EBREAK could reach it",
                     halt_cycles);
            $display("TEST FAILED");
            $fatal(1);
        end

        // Let any younger instruction try to write before reading back
        repeat (settle_cycles) @(posedge clk);
        check_registers();

        $display("TEST OK");
        $finish;
    end

endmodule

/* test/top_cpu_properties.sv */
module top_cpu_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     stall,
    input logic                     halted,
    input logic [cpu_pkg::xlen-1:0] x0_value
);
    timeunit 1ns;
    timeprecision 100ps;

    // The bubble from a load-use stall clears the hazard one cycle later
    stall_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) stall |=> !stall
    ) else $error("stall stayed high for two consecutive cycles");

    // Only reset clears a halt
    halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else $error("halted fell while rst_n was high");

    // Storage of x0 stays zero whatever writeback attempts
    no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n) x0_value == '0
    ) else $error("register x0 took a nonzero value");

endmodule

/* logic/top_cpu.sv */
module top_cpu (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    // Instruction memory load port
    input  logic                            imem_we,
    input  logic [cpu_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0]        imem_wdata,
    // Register file debug read
    input  logic [cpu_pkg::reg_addr_w-1:0]  dbg_addr,
    output logic [cpu_pkg::xlen-1:0]        dbg_data,
    output logic                            halted
);

    logic                     stall;
    logic                     branch_taken;
    logic [cpu_pkg::xlen-1:0] branch_target;

    fd_if u_fd_if ();
    de_if u_de_if ();
    em_if u_em_if ();
    wb_if u_wb_if ();

    fetch_stage u_fetch (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .imem_we       (imem_we),
        .imem_addr     (imem_addr),
        .imem_wdata    (imem_wdata),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halted        (halted),
        .fd            (u_fd_if.source)
    );

    decode_stage u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .halted       (halted),
        .branch_taken (branch_taken),
        .fd           (u_fd_if.sink),
        .wb           (u_wb_if.sink),
        .de           (u_de_if.source),
        .stall        (stall),
        .dbg_addr     (dbg_addr),
        .dbg_data     (dbg_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .halted        (halted),
        .de            (u_de_if.sink),
        .em            (u_em_if.source),
        .wb            (u_wb_if.sink),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    memory_stage u_memory (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .em     (u_em_if.sink),
        .wb     (u_wb_if.source),
        .halted (halted)
    );

endmodule

/* logic/memory_stage.sv */
module memory_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    em_if.sink   em,
    wb_if.source wb,
    output logic halted
);
    import cpu_pkg::*;

    logic [xlen-1:0]        dmem [dmem_depth];
    logic [dmem_addr_w-1:0] dmem_addr;
    logic [xlen-1:0]        load_data;
    logic                   mw_reg_write;
    logic                   mw_mem_to_reg;
    logic [reg_addr_w-1:0]  mw_rd;
    logic [xlen-1:0]        mw_load_data;
    logic [xlen-1:0]        mw_alu_result;

    // Word addressed, byte offset dropped
    assign dmem_addr = em.alu_result[dmem_addr_w+1:2];
    assign load_data = em.mem_read ? dmem[dmem_addr] : '0;

    always_ff @(posedge clk) begin
        if (em.mem_write && !halted) begin
            dmem[dmem_addr] <= em.store_data;
        end
    end

    // Sticky once EBREAK enters MEM/WB
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            halted <= 1'b0;
        end else if (em.is_halt) begin
            halted <= 1'b1;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst_n || !run || halted) begin
            mw_reg_write  <= 1'b0;
            mw_mem_to_reg <= 1'b0;
        end else begin
            mw_reg_write  <= em.reg_write;
            mw_mem_to_reg <= em.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mw_rd         <= em.rd;
        mw_load_data  <= load_data;
        mw_alu_result <= em.alu_result;
    end

    assign wb.reg_write = mw_reg_write;
    assign wb.rd        = mw_rd;
    assign wb.wdata     = mw_mem_to_reg ? mw_load_data : mw_alu_result;

endmodule

/* logic/execute_stage.sv */
module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     run,
    input  logic                     halted,
    de_if.sink                       de,
    em_if.source                     em,
    wb_if.sink                       wb,
    output logic                     branch_taken,
    output logic [cpu_pkg::xlen-1:0] branch_target
);
    import cpu_pkg::*;

    logic [xlen-1:0] fwd_a;
    logic [xlen-1:0] fwd_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_out;
    logic            operands_eq;

    // Operand A, EX/MEM result is younger than writeback
    always_comb begin
        if (em.reg_write && !em.mem_read && (em.rd != '0) && (em.rd == de.rs1)) begin
            fwd_a = em.alu_result;
        end else if (wb.reg_write && (wb.rd != '0) && (wb.rd == de.rs1)) begin
            fwd_a = wb.wdata;
        end else begin
            fwd_a = de.rs1_val;
        end
    end

    // Operand B, same priority
    always_comb begin
        if (em.reg_write && !em.mem_read && (em.rd != '0) && (em.rd == de.rs2)) begin
            fwd_b = em.alu_result;
        end else if (wb.reg_write && (wb.rd != '0) && (wb.rd == de.rs2)) begin
            fwd_b = wb.wdata;
        end else begin
            fwd_b = de.rs2_val;
        end
    end

    assign op_b = de.alu_src ? de.imm : fwd_b;

    always_comb begin
        case (de.alu_op)
            alu_add: alu_out = fwd_a + op_b;
            alu_sub: alu_out = fwd_a - op_b;
            alu_and: alu_out = fwd_a & op_b;
            alu_or:  alu_out = fwd_a | op_b;
            alu_xor: alu_out = fwd_a ^ op_b;
            alu_slt: alu_out = ($signed(fwd_a) < $signed(op_b)) ? xlen'(1) : '0;
            default: alu_out = '0;
        endcase
    end

    // BEQ and BNE resolve here
    assign operands_eq   = (fwd_a == fwd_b);
    assign branch_taken  = de.is_branch && !halted && (operands_eq != de.branch_ne);
    assign branch_target = de.pc + de.imm;

    // EX/MEM control bits
    always_ff @(posedge clk) begin
        if (!rst_n || !run || halted) begin
            em.reg_write  <= 1'b0;
            em.mem_read   <= 1'b0;
            em.mem_write  <= 1'b0;
            em.mem_to_reg <= 1'b0;
            em.is_halt    <= 1'b0;
        end else begin
            em.reg_write  <= de.reg_write;
            em.mem_read   <= de.mem_read;
            em.mem_write  <= de.mem_write;
            em.mem_to_reg <= de.mem_to_reg;
            em.is_halt    <= de.is_halt;
        end
    end

    always_ff @(posedge clk) begin
        em.rd         <= de.rd;
        em.alu_result <= alu_out;
        em.store_data <= fwd_b;
    end

endmodule

/* logic/decode_stage.sv */
module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           halted,
    input  logic                           branch_taken,
    fd_if.sink                             fd,
    wb_if.sink                             wb,
    de_if.source                           de,
    output logic                           stall,
    input  logic [cpu_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [cpu_pkg::xlen-1:0]       dbg_data
);
    import cpu_pkg::*;

    logic [xlen-1:0]       regs [reg_count];
    opcode_e               opcode;
    logic [2:0]            funct3;
    logic                  funct7_5;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_s;
    logic [xlen-1:0]       imm_b;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  alu_src;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_halt;
    logic                  uses_rs2;
    alu_op_e               alu_op;
    logic                  rf_we;
    logic                  bubble;

    assign opcode   = opcode_e'(fd.inst[6:0]);
    assign funct3   = fd.inst[14:12];
    assign funct7_5 = fd.inst[30];
    assign rs1      = fd.inst[19:15];
    assign rs2      = fd.inst[24:20];
    assign rd       = fd.inst[11:7];

    // Immediate formats
    assign imm_i = {{20{fd.inst[31]}}, fd.inst[31:20]};
    assign imm_s = {{20{fd.inst[31]}}, fd.inst[31:25], fd.inst[11:7]};
    assign imm_b = {{19{fd.inst[31]}}, fd.inst[31], fd.inst[7], fd.inst[30:25],
                    fd.inst[11:8], 1'b0};

    always_comb begin
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        alu_src    = 1'b0;
        is_branch  = 1'b0;
        branch_ne  = 1'b0;
        is_halt    = 1'b0;
        uses_rs2   = 1'b0;
        alu_op     = alu_add;
        imm        = imm_i;
        case (opcode)
            op_reg: begin
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
                case (funct3)
                    f3_add_sub: alu_op = funct7_5 ? alu_sub : alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    default:    alu_op = alu_add;
                endcase
            end
            op_imm: begin
                reg_write = 1'b1;
                alu_src   = 1'b1;
            end
            op_load: begin
                reg_write  = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                alu_src    = 1'b1;
            end
            op_store: begin
                mem_write = 1'b1;
                alu_src   = 1'b1;
                uses_rs2  = 1'b1;
                imm       = imm_s;
            end
            op_branch: begin
                is_branch = 1'b1;
                branch_ne = (funct3 == f3_bne);
                uses_rs2  = 1'b1;
                alu_op    = alu_sub;
                imm       = imm_b;
            end
            op_system: is_halt = (fd.inst == ebreak_inst);
            default: ;
        endcase
    end

    // Register file, x0 never written
    assign rf_we = wb.reg_write && (wb.rd != '0) && !halted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

    // Same-cycle writeback is bypassed onto the read ports
    always_comb begin
        if (rs1 == '0) begin
            rs1_val = '0;
        end else if (rf_we && (wb.rd == rs1)) begin
            rs1_val = wb.wdata;
        end else begin
            rs1_val = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_val = '0;
        end else if (rf_we && (wb.rd == rs2)) begin
            rs2_val = wb.wdata;
        end else begin
            rs2_val = regs[rs2];
        end
    end

    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

    // Load-use hazard against the instruction now in ID/EX
    assign stall = de.mem_read && (de.rd != '0) &&
                   ((de.rd == rs1) || (uses_rs2 && (de.rd == rs2)));

    assign bubble = stall || branch_taken || halted;

    // ID/EX control bits
    always_ff @(posedge clk) begin
        if (!rst_n || !run || bubble) begin
            de.reg_write  <= 1'b0;
            de.mem_read   <= 1'b0;
            de.mem_write  <= 1'b0;
            de.mem_to_reg <= 1'b0;
            de.alu_src    <= 1'b0;
            de.is_branch  <= 1'b0;
            de.branch_ne  <= 1'b0;
            de.is_halt    <= 1'b0;
        end else begin
            de.reg_write  <= reg_write;
            de.mem_read   <= mem_read;
            de.mem_write  <= mem_write;
            de.mem_to_reg <= mem_to_reg;
            de.alu_src    <= alu_src;
            de.is_branch  <= is_branch;
            de.branch_ne  <= branch_ne;
            de.is_halt    <= is_halt;
        end
    end

    // ID/EX operands
    always_ff @(posedge clk) begin
        de.alu_op  <= alu_op;
        de.pc      <= fd.pc;
        de.rs1     <= rs1;
        de.rs2     <= rs2;
        de.rd      <= rd;
        de.rs1_val <= rs1_val;
        de.rs2_val <= rs2_val;
        de.imm     <= imm;
    end

endmodule

/* logic/fetch_stage.sv */
module fetch_stage (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            run,
    input  logic                            imem_we,
    input  logic [cpu_pkg::imem_addr_w-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0]        imem_wdata,
    input  logic                            stall,
    input  logic                            branch_taken,
    input  logic [cpu_pkg::xlen-1:0]        branch_target,
    input  logic                            halted,
    fd_if.source                            fd
);
    import cpu_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [imem_depth];
    logic [xlen-1:0] fetched;

    // Program load, only while the core sits idle
    always_ff @(posedge clk) begin
        if (imem_we && !run) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Word-aligned read, PC bits above the array are ignored
    assign fetched = imem[pc[imem_addr_w+1:2]];

    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            pc <= '0;
        end else if (!halted) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (!stall) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rst_n || !run) begin
            fd.pc   <= '0;
            fd.inst <= nop_inst;
        end else if (!halted) begin
            if (branch_taken) begin
                // Squash the wrong-path fetch
                fd.inst <= nop_inst;
            end else if (!stall) begin
                fd.pc   <= pc;
                fd.inst <= fetched;
            end
        end
    end

endmodule

/* logic/pipe_if.sv */
// IF/ID register
interface fd_if;
    import cpu_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;

    modport source (output pc, inst);
    modport sink   (input pc, inst);
endinterface

// ID/EX register
interface de_if;
    import cpu_pkg::*;

    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  alu_src;
    logic                  is_branch;
    logic                  branch_ne;
    logic                  is_halt;
    alu_op_e               alu_op;
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rs1_val;
    logic [xlen-1:0]       rs2_val;
    logic [xlen-1:0]       imm;

    modport source (output reg_write, mem_read, mem_write, mem_to_reg, alu_src, is_branch,
                    branch_ne, is_halt, alu_op, pc, rs1, rs2, rd, rs1_val, rs2_val, imm);
    modport sink   (input reg_write, mem_read, mem_write, mem_to_reg, alu_src, is_branch,
                    branch_ne, is_halt, alu_op, pc, rs1, rs2, rd, rs1_val, rs2_val, imm);
endinterface

// EX/MEM register
interface em_if;
    import cpu_pkg::*;

    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  is_halt;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       alu_result;
    logic [xlen-1:0]       store_data;

    modport source (output reg_write, mem_read, mem_write, mem_to_reg, is_halt, rd,
                    alu_result, store_data);
    modport sink   (input reg_write, mem_read, mem_write, mem_to_reg, is_halt, rd,
                    alu_result, store_data);
endinterface

// Writeback path out of MEM/WB
interface wb_if;
    import cpu_pkg::*;

    logic                  reg_write;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       wdata;

    modport source (output reg_write, rd, wdata);
    modport sink   (input reg_write, rd, wdata);
endinterface

/* logic/cpu_pkg.sv */
package cpu_pkg;

    // Datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 32;

    // Memory sizes, in 32-bit words
    localparam int imem_depth  = 64;
    localparam int dmem_depth  = 64;
    localparam int imem_addr_w = 6;
    localparam int dmem_addr_w = 6;

    // ADDI x0, x0, 0 doubles as the pipeline bubble
    localparam logic [xlen-1:0] nop_inst    = 32'h0000_0013;
    localparam logic [xlen-1:0] ebreak_inst = 32'h0010_0073;

    // funct3 codes of the supported subset
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_bne     = 3'b001;

    // Major opcodes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_system = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5
    } alu_op_e;

endpackage
